//--- src.f
source/periph_pkg.sv
source/sb_if.sv
source/sb_decoder.sv
source/led_sb_ctrl.sv
source/sw_sb_ctrl.sv
source/periph_top.sv
dv/periph_tb.sv

//--- dv/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;

    localparam int unsigned TB_BLINK_HALF = 4;  // short blink so a period fits in a few cycles

    typedef enum {OP_IDLE, OP_WRITE, OP_READ, OP_BLINK} op_e;

    logic                        clk_i;
    logic                        rst_i;
    logic                        req_i;
    logic                        we_i;
    logic [31:0]                 addr_i;
    logic [31:0]                 wdata_i;
    logic [31:0]                 rdata_o;
    logic [periph_pkg::IO_W-1:0] sw_i;
    logic [periph_pkg::IO_W-1:0] led_o;

    // stimulus table, one column per queue
    op_e         t_op[$];
    logic [31:0] t_addr[$];
    logic [31:0] t_wdata[$];
    logic [15:0] t_sw[$];
    logic [31:0] t_exp_rd[$];
    logic        t_chk_led[$];
    logic [15:0] t_exp_led[$];

    logic [15:0] cur_sw;       // switch pattern carried into new entries
    bit          table_ready;
    int          errors;

    periph_top #(
        .BLINK_HALF (TB_BLINK_HALF)
    ) uut (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .sw_i    (sw_i),
        .led_o   (led_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display(">>> FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic add_entry(input op_e op, input logic [7:0] dev, input logic [23:0] ofs,
                             input logic [31:0] wdata, input logic [31:0] exp_rd,
                             input logic chk_led, input logic [15:0] exp_led);
        t_op.push_back(op);
        t_addr.push_back({dev, ofs});
        t_wdata.push_back(wdata);
        t_sw.push_back(cur_sw);
        t_exp_rd.push_back(exp_rd);
        t_chk_led.push_back(chk_led);
        t_exp_led.push_back(exp_led);
    endtask

    task automatic add_write(input logic [7:0] dev, input logic [23:0] ofs,
                             input logic [31:0] wdata, input logic chk_led,
                             input logic [15:0] exp_led);
        add_entry(OP_WRITE, dev, ofs, wdata, 32'd0, chk_led, exp_led);
    endtask

    task automatic add_read(input logic [7:0] dev, input logic [23:0] ofs,
                            input logic [31:0] exp_rd);
        add_entry(OP_READ, dev, ofs, 32'd0, exp_rd, 1'b0, 16'd0);
    endtask

    task automatic add_idle(input logic chk_led, input logic [15:0] exp_led);
        add_entry(OP_IDLE, 8'h00, 24'h0, 32'd0, 32'd0, chk_led, exp_led);
    endtask

    task automatic set_switches(input logic [15:0] pattern);
        cur_sw = pattern;
        add_idle(1'b0, 16'd0);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        logic [15:0] pat_a;
        logic [15:0] pat_b;
        logic [15:0] pat_c;
        logic [15:0] sw_a;
        logic [15:0] sw_b;
        rnd   = $urandom;
        pat_a = rnd[15:0] | 16'h0001;  // never all dark
        rnd   = $urandom;
        pat_b = rnd[15:0] | 16'h0100;
        rnd   = $urandom;
        pat_c = rnd[15:0] | 16'h8000;
        rnd   = $urandom;
        sw_a  = rnd[15:0] | 16'h0010;
        sw_b  = ~sw_a;

        // every register reads 0 out of reset
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, 32'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_VAL_OFS, 32'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd0);

        add_write(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_a}, 1'b1, pat_a);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_a});
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'h0001, pat_b}, 1'b1, pat_a);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_a});

        // blink on, one full period observed, then back to steady
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd1, 1'b0, 16'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd1);
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd2, 1'b0, 16'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd1);  // mode 2 ignored
        add_entry(OP_BLINK, 8'h00, 24'h0, 32'd0, 32'd0, 1'b0, pat_a);
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd0, 1'b0, 16'd0);
        add_idle(1'b1, pat_a);  // counter parked by now
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd0);

        // soft reset
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_b}, 1'b1, pat_b);
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd1, 1'b0, 16'd0);
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_RST_OFS, 32'd2, 1'b0, 16'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_b});
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd1);
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_RST_OFS, 32'd1, 1'b1, 16'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, 32'd0);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd0);
        add_idle(1'b1, 16'd0);

        // switches need the synchronizer to settle before the read
        set_switches(sw_a);
        add_idle(1'b0, 16'd0);
        add_idle(1'b0, 16'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_VAL_OFS, {16'd0, sw_a});
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd1);
        add_write(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd1, 1'b0, 16'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd0);
        set_switches(sw_b);
        add_idle(1'b0, 16'd0);
        add_idle(1'b0, 16'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_VAL_OFS, {16'd0, sw_b});
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd1);
        add_write(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd1, 1'b0, 16'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd0);

        // unmapped devices and offsets, with a live led value to alias against
        add_write(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_c}, 1'b1, pat_c);
        add_read(8'h03, 24'h0, 32'd0);
        add_read(8'h00, periph_pkg::LED_VAL_OFS, 32'd0);
        add_read(periph_pkg::DEV_LED, 24'h08, 32'd0);
        add_read(periph_pkg::DEV_SW, 24'h08, 32'd0);
        add_write(8'h03, periph_pkg::LED_VAL_OFS, 32'h0000_ffff, 1'b1, pat_c);
        add_write(8'h03, periph_pkg::LED_RST_OFS, 32'd1, 1'b1, pat_c);
        add_write(8'hff, periph_pkg::LED_MODE_OFS, 32'd1, 1'b1, pat_c);
        add_write(periph_pkg::DEV_LED, 24'h08, 32'd1, 1'b1, pat_c);
        add_write(periph_pkg::DEV_SW, 24'h08, 32'd1, 1'b1, pat_c);
        add_write(periph_pkg::DEV_SW, periph_pkg::SW_VAL_OFS, 32'h0000_1234, 1'b1, pat_c);
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_VAL_OFS, {16'd0, pat_c});
        add_read(periph_pkg::DEV_LED, periph_pkg::LED_MODE_OFS, 32'd0);
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_VAL_OFS, {16'd0, sw_b});
        add_read(periph_pkg::DEV_SW, periph_pkg::SW_FLAG_OFS, 32'd0);
    endtask

    task automatic run_entry(input int idx);
        int on_cnt;
        int off_cnt;
        on_cnt  = 0;
        off_cnt = 0;
        req_i   = (t_op[idx] == OP_WRITE) || (t_op[idx] == OP_READ);
        we_i    = (t_op[idx] == OP_WRITE);
        addr_i  = t_addr[idx];
        wdata_i = t_wdata[idx];
        sw_i    = t_sw[idx];
        @(posedge clk_i);
        #1;
        if (t_op[idx] == OP_READ) begin
            check_eq($sformatf("read data of entry %0d", idx), rdata_o, t_exp_rd[idx]);
        end
        if (t_chk_led[idx]) begin
            check_eq($sformatf("led_o after entry %0d", idx), led_o, t_exp_led[idx]);
        end
        if (t_op[idx] == OP_BLINK) begin
            for (int c = 0; c < 2 * TB_BLINK_HALF; c++) begin
                if (led_o == t_exp_led[idx]) begin
                    on_cnt++;
                end else if (led_o == '0) begin
                    off_cnt++;
                end
                @(posedge clk_i);
                #1;
            end
            check_eq("blink cycles lit", on_cnt, TB_BLINK_HALF);
            check_eq("blink cycles dark", off_cnt, TB_BLINK_HALF);
        end
    endtask

    initial begin
        void'($urandom(95257));
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        wdata_i     = '0;
        sw_i        = '0;
        cur_sw      = '0;
        errors      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_eq("rdata_o after reset", rdata_o, 32'd0);
        check_eq("led_o after reset", led_o, 32'd0);

        for (int i = 0; i < t_op.size(); i++) begin
            run_entry(i);
        end
        req_i = 1'b0;
        we_i  = 1'b0;
        @(posedge clk_i);

        if (errors == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "%0d checks failed", errors);
        end
    end

    // budget of ten cycles per table entry plus margin for reset
    initial begin
        wait (table_ready);
        repeat (t_op.size() * 10 + 200) @(posedge clk_i);
        $display("watchdog expired before the stimulus table finished");
        $display(">>> FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- source/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int unsigned BLINK_HALF = periph_pkg::BLINK_HALF_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic                        req_i,
    input  logic                        we_i,
    input  logic [31:0]                 addr_i,
    input  logic [31:0]                 wdata_i,
    output logic [31:0]                 rdata_o,
    input  logic [periph_pkg::IO_W-1:0] sw_i,
    output logic [periph_pkg::IO_W-1:0] led_o
);

    periph_pkg::sb_addr_u addr_u;

    assign addr_u.raw = addr_i;

    sb_if led_bus ();
    sb_if sw_bus ();

    sb_decoder u_dec (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .req_i   (req_i),
        .we_i    (we_i),
        .addr_i  (addr_u),
        .wdata_i (wdata_i),
        .rdata_o (rdata_o),
        .led_bus (led_bus),
        .sw_bus  (sw_bus)
    );

    led_sb_ctrl #(
        .BLINK_HALF (BLINK_HALF)
    ) u_led (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (led_bus),
        .led_o (led_o)
    );

    sw_sb_ctrl u_sw (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .bus   (sw_bus),
        .sw_i  (sw_i)
    );

endmodule

//--- source/sw_sb_ctrl.sv
`timescale 1ns/1ps

module sw_sb_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_i,
    sb_if.slave                         bus,
    input  logic [periph_pkg::IO_W-1:0] sw_i
);

    logic [periph_pkg::IO_W-1:0] sw_meta;
    logic [periph_pkg::IO_W-1:0] sw_sync;
    logic [periph_pkg::IO_W-1:0] sw_prev;
    logic                        sw_flag;
    logic                        sw_changed;
    logic                        flag_clr;
    logic                        rd;
    logic [23:0]                 ofs;

    // two-flop synchronizer, settles while reset is held
    always_ff @(posedge clk_i) begin
        sw_meta <= sw_i;
        sw_sync <= sw_meta;
        sw_prev <= sw_sync;
    end

    assign ofs        = bus.addr.fld.offset;
    assign rd         = bus.req & ~bus.we;
    assign sw_changed = (sw_sync != sw_prev);
    assign flag_clr   = bus.req && bus.we && (ofs == periph_pkg::SW_FLAG_OFS)
                        && (bus.wdata == 32'd1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sw_flag <= 1'b0;
        end else if (sw_changed) begin
            sw_flag <= 1'b1;  // a fresh change beats the clear
        end else if (flag_clr) begin
            sw_flag <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd) begin
            case (ofs)
                periph_pkg::SW_VAL_OFS:  bus.rdata <= {{(32 - periph_pkg::IO_W){1'b0}}, sw_sync};
                periph_pkg::SW_FLAG_OFS: bus.rdata <= {31'd0, sw_flag};
                default:                 bus.rdata <= '0;
            endcase
        end
    end

    a_change_sets_flag: assert property (
        @(posedge clk_i) disable iff (rst_i)
        sw_changed |=> sw_flag
    ) else $error("switch change did not raise the flag");

endmodule

//--- source/led_sb_ctrl.sv
`timescale 1ns/1ps

module led_sb_ctrl #(
    parameter int unsigned BLINK_HALF = periph_pkg::BLINK_HALF_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    sb_if.slave                         bus,
    output logic [periph_pkg::IO_W-1:0] led_o
);

    logic [periph_pkg::IO_W-1:0] led_val;
    logic                        led_mode;
    logic [31:0]                 cntr;
    logic [23:0]                 ofs;
    logic                        wr;
    logic                        rd;
    logic                        soft_rst;
    logic                        val_we;
    logic                        mode_we;
    logic                        cntr_wrap;

    assign ofs = bus.addr.fld.offset;
    assign wr  = bus.req & bus.we;
    assign rd  = bus.req & ~bus.we;

    // only an exact 1 at the reset offset counts
    assign soft_rst = wr && (ofs == periph_pkg::LED_RST_OFS) && (bus.wdata == 32'd1);

    assign val_we  = wr && (ofs == periph_pkg::LED_VAL_OFS)
                     && (bus.wdata[31:periph_pkg::IO_W] == '0);
    assign mode_we = wr && (ofs == periph_pkg::LED_MODE_OFS) && (bus.wdata <= 32'd1);

    always_ff @(posedge clk_i) begin
        if (rst_i || soft_rst) begin
            led_val  <= '0;
            led_mode <= 1'b0;
        end else begin
            if (val_we) begin
                led_val <= bus.wdata[periph_pkg::IO_W-1:0];
            end
            if (mode_we) begin
                led_mode <= bus.wdata[0];
            end
        end
    end

    assign cntr_wrap = (cntr == 32'(2 * BLINK_HALF - 1));

    // blink period is 2*BLINK_HALF, parked at 0 in steady mode
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cntr <= '0;
        end else if (soft_rst || !led_mode || cntr_wrap) begin
            cntr <= '0;
        end else begin
            cntr <= cntr + 32'd1;
        end
    end

    assign led_o = (cntr < 32'(BLINK_HALF)) ? led_val : '0;  // dark in second half

    always_ff @(posedge clk_i) begin
        if (soft_rst) begin
            bus.rdata <= '0;
        end else if (rd) begin
            case (ofs)
                periph_pkg::LED_VAL_OFS:  bus.rdata <= {{(32 - periph_pkg::IO_W){1'b0}}, led_val};
                periph_pkg::LED_MODE_OFS: bus.rdata <= {31'd0, led_mode};
                default:                  bus.rdata <= '0;
            endcase
        end
    end

    a_soft_rst_dark: assert property (
        @(posedge clk_i) disable iff (rst_i)
        soft_rst |=> (led_o == '0)
    ) else $error("led_o not dark after soft reset");

    a_cntr_range: assert property (
        @(posedge clk_i) disable iff (rst_i)
        cntr < 32'(2 * BLINK_HALF)
    ) else $error("blink counter out of range");

endmodule

//--- source/sb_decoder.sv
`timescale 1ns/1ps

module sb_decoder (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 req_i,
    input  logic                 we_i,
    input  periph_pkg::sb_addr_u addr_i,
    input  logic [31:0]          wdata_i,
    output logic [31:0]          rdata_o,
    sb_if.master                 led_bus,
    sb_if.master                 sw_bus
);

    logic hit_led;
    logic hit_sw;
    logic rd_sel_led;
    logic rd_sel_sw;

    assign hit_led = (addr_i.fld.dev == periph_pkg::DEV_LED);
    assign hit_sw  = (addr_i.fld.dev == periph_pkg::DEV_SW);

    // request goes to one slave at most, the rest is broadcast
    assign led_bus.req   = req_i & hit_led;
    assign led_bus.we    = we_i;
    assign led_bus.addr  = addr_i;
    assign led_bus.wdata = wdata_i;

    assign sw_bus.req   = req_i & hit_sw;
    assign sw_bus.we    = we_i;
    assign sw_bus.addr  = addr_i;
    assign sw_bus.wdata = wdata_i;

    // which slave owns the data of the last read
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_sel_led <= 1'b0;
            rd_sel_sw  <= 1'b0;
        end else if (req_i && !we_i) begin
            rd_sel_led <= hit_led;
            rd_sel_sw  <= hit_sw;  // both low for an unmapped device
        end
    end

    always_comb begin
        if (rd_sel_led) begin
            rdata_o = led_bus.rdata;
        end else if (rd_sel_sw) begin
            rdata_o = sw_bus.rdata;
        end else begin
            rdata_o = '0;
        end
    end

    a_one_slave_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(led_bus.req && sw_bus.req)
    ) else $error("both slaves requested in the same cycle");

endmodule

//--- source/sb_if.sv
`timescale 1ns/1ps

interface sb_if;

    logic                 req;
    logic                 we;
    periph_pkg::sb_addr_u addr;
    logic [31:0]          wdata;
    logic [31:0]          rdata;  // registered in the slave, valid one cycle after req

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

//--- source/periph_pkg.sv
package periph_pkg;

    // device codes live in the top byte of the bus address
    localparam logic [7:0] DEV_SW  = 8'h01;
    localparam logic [7:0] DEV_LED = 8'h02;

    // led bank register map
    localparam logic [23:0] LED_VAL_OFS  = 24'h00;
    localparam logic [23:0] LED_MODE_OFS = 24'h04;
    localparam logic [23:0] LED_RST_OFS  = 24'h24;

    // switch bank register map
    localparam logic [23:0] SW_VAL_OFS  = 24'h00;
    localparam logic [23:0] SW_FLAG_OFS = 24'h04;

    localparam int unsigned IO_W = 16;                   // leds and switches per bank

    localparam int unsigned BLINK_HALF_DEF = 10_000_000; // ~0.1 s on a 100 MHz clock

    // one address word, seen raw by the top and split by the decoder and slaves
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0]  dev;    // slave select
            logic [23:0] offset; // register inside the slave
        } fld;
    } sb_addr_u;

endpackage
